// ==== tb.f ====
bp_pkg.sv
line_predecode.sv
gshare_predictor.sv
return_stack.sv
fetch_sequencer.sv
branch_pred_top.sv
tb_branch_pred.sv

// ==== Bender.yml ====
package:
  name: branch_pred

sources:
  - bp_pkg.sv
  - line_predecode.sv
  - gshare_predictor.sv
  - return_stack.sv
  - fetch_sequencer.sv
  - branch_pred_top.sv
  - target: simulation
    files:
      - tb_branch_pred.sv

// ==== tb_branch_pred.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_branch_pred
  import bp_pkg::*;
();

  localparam int          N_PRED     = 300;                   // accepted predictions to run
  localparam int          MAX_CYCLES = 40 * N_PRED;
  localparam logic [63:0] START_PC   = 64'h0000_0000_0001_0000;
  localparam logic [31:0] SEED       = 32'h19f1_4f7c;
  localparam int          M_IDLE     = 0;
  localparam int          M_WAIT     = 1;
  localparam int          M_HOLD     = 2;

  logic                  clk_in;
  logic                  rst_N_in;
  logic                  start;
  logic [XLEN-1:0]       start_pc;
  logic                  line_valid;
  logic [LINE_BITS-1:0]  line_data;
  logic                  fetch_ready;
  resolve_t              resolve;
  redirect_t             redirect;
  logic                  line_req;
  logic [XLEN-1:0]       line_addr;
  logic                  pred_valid;
  logic [XLEN-1:0]       pred_pc;
  branch_group_t         decode_branches;

  // reference model state
  int                    m_state;
  logic                  m_drop;          // next returning line is stale
  logic [63:0]           m_drop_pc;
  logic [63:0]           m_gpc;           // address of the line in flight
  logic                  e_req;
  logic                  e_pv;
  logic [63:0]           e_pc;
  branch_group_t         e_dec;
  logic [GHR_K-1:0]      m_ghr;
  logic [1:0]            m_pht [PHT_SIZE];
  logic [63:0]           ras_q [$];       // back of the queue is the top

  // memory model
  logic                  mem_busy;
  int                    mem_wait;
  logic [63:0]           mem_addr;

  logic [31:0]           rng;
  logic                  started;
  logic                  restarted;       // second run begins from idle
  int                    errors;
  int                    checks;
  int                    cycles;
  int                    accepted;

  branch_pred_top branch_pred_top_i (
    .clk_in          (clk_in),
    .rst_N_in        (rst_N_in),
    .start           (start),
    .start_pc        (start_pc),
    .line_valid      (line_valid),
    .line_data       (line_data),
    .fetch_ready     (fetch_ready),
    .resolve         (resolve),
    .redirect        (redirect),
    .line_req        (line_req),
    .line_addr       (line_addr),
    .pred_valid      (pred_valid),
    .pred_pc         (pred_pc),
    .decode_branches (decode_branches)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // program image of mostly plain ops with small branch offsets
  function automatic logic [31:0] word_at(input logic [63:0] a);
    logic [31:0] h;
    logic [5:0]  off;
    h   = xorshift32(xorshift32(a[31:0] ^ a[63:32] ^ 32'h5bd1_e995));
    off = h[9:4];                                    // signed word offset -32..31
    case (h[31:28])
      4'd8:                return {OPC_B, {20{off[5]}}, off};
      4'd9, 4'd10:         return {OPC_BL, {20{off[5]}}, off};
      4'd11, 4'd12:        return {RET_PATTERN, 21'h1f_03c0};  // as many returns as calls
      4'd13, 4'd14, 4'd15: return {BCOND_PREFIX, {13{off[5]}}, off, 1'b0, h[3:0]};
      default:             return {8'h8b, h[23:0]};  // plain alu op
    endcase
  endfunction

  function automatic logic [LINE_BITS-1:0] build_line(input logic [63:0] a);
    logic [LINE_BITS-1:0] l;
    logic [63:0]          base;
    base = {a[63:6], 6'b000000};
    for (int w = 0; w < LINE_BYTES / 4; w++) begin
      l[32*w +: 32] = word_at(base + 64'(4 * w));   // byte 0 in bits 7:0
    end
    return l;
  endfunction

  task automatic report_mismatch(input string name, input logic [159:0] exp,
                                 input logic [159:0] act);
    errors++;
    $display("FAIL %s: expected %h, actual %h", name, exp, act);
  endtask

  // scan the group at m_gpc, set the expected prediction and update the model ras
  task automatic predict_group();
    logic [63:0] a;
    logic [31:0] w;
    logic [63:0] imm;
    logic [63:0] tgt;
    logic [63:0] link;
    logic        found;
    logic        do_push;
    logic        do_pop;
    int          nval;
    found   = 1'b0;
    do_push = 1'b0;
    do_pop  = 1'b0;
    tgt     = '0;
    link    = '0;
    nval    = 0;
    e_dec   = '0;
    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
      a = m_gpc + 64'(4 * i);
      if (!found && int'(m_gpc[5:0]) + 4 * i <= LINE_BYTES - 4) begin
        w = word_at(a);
        nval++;
        e_dec[i].valid = 1'b1;
        if (w[31:26] == OPC_B || w[31:26] == OPC_BL) begin
          imm                    = {{38{w[25]}}, w[25:0]};
          e_dec[i].kind          = (w[31:26] == OPC_B) ? B : BL;
          e_dec[i].predict_taken = 1'b1;
          e_dec[i].target        = a + (imm << 2);
        end else if (w[31:21] == RET_PATTERN) begin
          e_dec[i].kind          = RET;
          e_dec[i].predict_taken = 1'b1;
          e_dec[i].target        = (ras_q.size() > 0) ? ras_q[$] : 64'h0;  // empty reads 0
        end else if (w[31:24] == BCOND_PREFIX) begin
          imm                    = {{45{w[23]}}, w[23:5]};
          e_dec[i].kind          = BCOND;
          e_dec[i].cond          = w[3:0];
          e_dec[i].target        = a + (imm << 2);
          e_dec[i].predict_taken = m_pht[{m_ghr, a[PHT_N+1:2]}] >= 2;
        end
        if (e_dec[i].predict_taken) begin
          found   = 1'b1;                            // later slots stay invalid
          tgt     = e_dec[i].target;
          do_push = (e_dec[i].kind == BL);
          do_pop  = (e_dec[i].kind == RET);
          link    = a + 64'd4;
        end
      end
    end
    e_pc = found ? tgt : m_gpc + 64'(4 * nval);
    if (do_push) begin
      ras_q.push_back(link);
      if (ras_q.size() > RAS_DEPTH) begin
        void'(ras_q.pop_front());                    // oldest entry lost
      end
    end
    if (do_pop && ras_q.size() > 0) begin
      void'(ras_q.pop_back());
    end
  endtask

  task automatic train_model();
    logic [PHT_N+GHR_K-1:0] idx;
    if (resolve.valid) begin
      idx = {m_ghr, resolve.pc[PHT_N+1:2]};
      if (resolve.taken && m_pht[idx] != 2'd3) begin
        m_pht[idx] = m_pht[idx] + 2'd1;
      end else if (!resolve.taken && m_pht[idx] != 2'd0) begin
        m_pht[idx] = m_pht[idx] - 2'd1;
      end
      m_ghr = {m_ghr[GHR_K-2:0], resolve.taken};
    end
  endtask

  // what the next clock edge should do with the inputs just driven
  task automatic model_step();
    logic        req;
    logic [63:0] raddr;
    req   = 1'b0;
    raddr = '0;
    case (m_state)
      M_IDLE: begin
        if (redirect.valid || start) begin
          req     = 1'b1;
          raddr   = redirect.valid ? redirect.pc : start_pc;
          m_state = M_WAIT;
        end
      end
      M_WAIT: begin
        if (line_valid && (redirect.valid || m_drop)) begin
          req    = 1'b1;                             // stale line gives no prediction
          raddr  = redirect.valid ? redirect.pc : m_drop_pc;
          m_drop = 1'b0;
        end else if (line_valid) begin
          predict_group();
          m_state = M_HOLD;
        end else if (redirect.valid) begin
          m_drop    = 1'b1;
          m_drop_pc = redirect.pc;
        end
      end
      default: begin
        if (redirect.valid || fetch_ready) begin
          req     = 1'b1;
          raddr   = redirect.valid ? redirect.pc : e_pc;
          m_state = M_WAIT;
        end
      end
    endcase
    train_model();                                   // lookups above saw the old tables
    e_req = req;
    if (req) begin
      m_gpc = raddr;
    end
    e_pv = (m_state == M_HOLD);
  endtask

  task automatic check_outputs();
    checks++;
    if (line_req !== e_req) report_mismatch("line_req", 160'(e_req), 160'(line_req));
    if (e_req && line_addr !== m_gpc) report_mismatch("line_addr", 160'(m_gpc), 160'(line_addr));
    if (pred_valid !== e_pv) report_mismatch("pred_valid", 160'(e_pv), 160'(pred_valid));
    if (e_pv && pred_pc !== e_pc) report_mismatch("pred_pc", 160'(e_pc), 160'(pred_pc));
    if (e_pv && decode_branches !== e_dec) begin
      report_mismatch("decode_branches", 160'(e_dec), 160'(decode_branches));
    end
  endtask

  // answers each request 1 to 4 cycles later
  task automatic serve_memory();
    line_valid = 1'b0;
    line_data  = '0;
    if (line_req && mem_busy) begin
      errors++;
      $display("line request issued while another line was still outstanding");
    end
    if (mem_busy) begin
      if (mem_wait == 0) begin
        line_valid = 1'b1;
        line_data  = build_line(mem_addr);
        mem_busy   = 1'b0;
      end else begin
        mem_wait--;
      end
    end
    if (line_req) begin
      mem_busy = 1'b1;
      mem_addr = line_addr;
      mem_wait = int'(next_rand() % 4);
    end
  endtask

  task automatic drive_stimulus();
    logic [31:0] r;
    start    = 1'b0;
    redirect = '0;
    resolve  = '0;
    if (!started) begin
      started = 1'b1;
      if (restarted) begin
        redirect.valid = 1'b1;                       // leave idle through a redirect
        redirect.pc    = START_PC + 64'((next_rand() % 1024) * 4);
      end else begin
        start    = 1'b1;
        start_pc = START_PC;
      end
    end else if (next_rand() % 25 == 0) begin
      redirect.valid = 1'b1;
      redirect.pc    = START_PC + 64'((next_rand() % 1024) * 4);
    end
    fetch_ready = (next_rand() % 8) < 5;             // back-pressure about 40% of cycles
    if (next_rand() % 3 == 0) begin
      r             = next_rand();
      resolve.valid = 1'b1;
      resolve.pc    = START_PC + 64'((next_rand() % 256) * 4);
      resolve.taken = resolve.pc[3] ? (r[1:0] != 2'd0) : (r[1:0] == 2'd0);  // biased per pc
    end
  endtask

  // hold reset for ten cycles and bring the model back to its cleared state
  task automatic apply_reset();
    rst_N_in    = 1'b1;
    start       = 1'b0;
    line_valid  = 1'b0;
    line_data   = '0;
    fetch_ready = 1'b0;
    resolve     = '0;
    redirect    = '0;
    started     = 1'b0;
    m_state     = M_IDLE;
    m_drop      = 1'b0;
    m_drop_pc   = '0;
    m_gpc       = '0;
    e_req       = 1'b0;
    e_pv        = 1'b0;
    e_pc        = '0;
    e_dec       = '0;
    m_ghr       = '0;
    mem_busy    = 1'b0;
    mem_wait    = 0;
    mem_addr    = '0;
    ras_q.delete();                                  // stack reads empty again
    for (int j = 0; j < PHT_SIZE; j++) begin
      m_pht[j] = 2'd0;
    end
    repeat (10) @(posedge clk_in);
    @(negedge clk_in);
    rst_N_in = 1'b0;
    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
      if (decode_branches[i].valid !== 1'b0) begin
        report_mismatch("reset decode valid", 160'(0), 160'(decode_branches[i].valid));
      end
    end
  endtask

  initial begin
    start_pc  = '0;
    rng       = SEED;
    restarted = 1'b0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    accepted  = 0;
    apply_reset();
    while (accepted < N_PRED && cycles < MAX_CYCLES) begin
      if (accepted == N_PRED / 2 && !restarted) begin
        restarted = 1'b1;
        apply_reset();                               // second half starts from idle
      end
      check_outputs();
      serve_memory();
      drive_stimulus();
      if (e_pv && fetch_ready && !redirect.valid) begin
        accepted++;                                  // fetch takes this prediction
      end
      model_step();
      @(negedge clk_in);
      cycles++;
    end
    if (accepted < N_PRED) begin
      errors++;
      $display("timeout after %0d cycles, only %0d of %0d predictions accepted",
               cycles, accepted, N_PRED);
    end
    $display("checks %0d, predictions %0d, errors %0d", checks, accepted, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== branch_pred_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_pred_top
  import bp_pkg::*;
(
  input  logic                    clk_in,
  input  logic                    rst_N_in,
  input  logic                    start,
  input  logic [XLEN-1:0]         start_pc,
  input  logic                    line_valid,
  input  logic [LINE_BITS-1:0]    line_data,
  input  logic                    fetch_ready,
  input  resolve_t                resolve,
  input  redirect_t               redirect,
  output logic                    line_req,
  output logic [XLEN-1:0]         line_addr,
  output logic                    pred_valid,
  output logic [XLEN-1:0]         pred_pc,
  output branch_group_t           decode_branches
);

  logic [XLEN-1:0]                      group_pc;     // pc of the group being scanned
  logic [LINE_BITS-1:0]                 group_line;
  slot_info_t [SUPER_SCALAR_WIDTH-1:0]  slots;
  logic [SUPER_SCALAR_WIDTH-1:0]        predict_taken;

  fetch_sequencer fetch_sequencer_i (
    .clk_in          (clk_in),
    .rst_N_in        (rst_N_in),
    .start           (start),
    .start_pc        (start_pc),
    .redirect        (redirect),
    .line_valid      (line_valid),
    .line_data       (line_data),
    .fetch_ready     (fetch_ready),
    .slots           (slots),
    .predict_taken   (predict_taken),
    .group_pc        (group_pc),
    .group_line      (group_line),
    .line_req        (line_req),
    .line_addr       (line_addr),
    .pred_valid      (pred_valid),
    .pred_pc         (pred_pc),
    .decode_branches (decode_branches)
  );

  // slot classification and targets
  line_predecode line_predecode_i (
    .group_pc  (group_pc),
    .line_data (group_line),
    .slots     (slots)
  );

  // direction for the conditional slots, trained by execute
  gshare_predictor gshare_predictor_i (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .group_pc      (group_pc),
    .resolve       (resolve),
    .predict_taken (predict_taken)
  );

endmodule

`default_nettype wire

// ==== fetch_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer
  import bp_pkg::*;
(
  input  logic                                  clk_in,
  input  logic                                  rst_N_in,
  input  logic                                  start,
  input  logic [XLEN-1:0]                       start_pc,
  input  redirect_t                             redirect,
  input  logic                                  line_valid,
  input  logic [LINE_BITS-1:0]                  line_data,
  input  logic                                  fetch_ready,
  input  slot_info_t [SUPER_SCALAR_WIDTH-1:0]   slots,
  input  logic [SUPER_SCALAR_WIDTH-1:0]         predict_taken,
  output logic [XLEN-1:0]                       group_pc,
  output logic [LINE_BITS-1:0]                  group_line,
  output logic                                  line_req,
  output logic [XLEN-1:0]                       line_addr,
  output logic                                  pred_valid,
  output logic [XLEN-1:0]                       pred_pc,
  output branch_group_t                         decode_branches
);

  typedef enum logic [1:0] {
    S_IDLE,   // waiting for start
    S_WAIT,   // one line outstanding
    S_HOLD    // prediction presented, waiting for fetch
  } seq_state_t;

  seq_state_t             state_q, state_d;
  logic                   drop_q, drop_d;          // discard the next returning line
  logic [XLEN-1:0]        redir_pc_q, redir_pc_d;  // pc to fetch once that line is gone
  logic [XLEN-1:0]        group_pc_q;
  logic                   req_d;
  logic [XLEN-1:0]        req_pc;
  logic                   take_line;
  logic                   found;
  logic                   is_end;
  logic                   end_is_bl;
  logic                   end_is_ret;
  logic [XLEN-1:0]        slot_pc;
  logic [XLEN-1:0]        end_pc;
  logic [XLEN-1:0]        end_target;
  logic [XLEN-1:0]        next_pc;
  logic [SLOT_CNT_W-1:0]  n_valid;
  branch_group_t          dec_d;
  logic [XLEN-1:0]        ras_top;

  return_stack ras_i (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .push      (take_line & end_is_bl),
    .pop       (take_line & end_is_ret),
    .push_addr (end_pc + XLEN'(INSTR_BYTES)),     // link address
    .top       (ras_top)
  );

  assign group_pc   = group_pc_q;
  assign group_line = line_data;   // predecoded in the cycle it returns
  assign line_addr  = group_pc_q;
  assign pred_valid = (state_q == S_HOLD);

  // find the ending slot and the next pc
  always_comb begin
    found      = 1'b0;
    is_end     = 1'b0;
    end_is_bl  = 1'b0;
    end_is_ret = 1'b0;
    slot_pc    = group_pc_q;
    end_pc     = group_pc_q;
    end_target = '0;
    n_valid    = '0;
    dec_d      = '0;
    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
      slot_pc = group_pc_q + XLEN'(INSTR_BYTES * i);
      is_end  = 1'b0;
      if (slots[i].valid && !found) begin       // slots after the end stay invalid
        n_valid              = n_valid + 1'b1;
        dec_d[i].valid       = 1'b1;
        dec_d[i].kind        = slots[i].kind;
        dec_d[i].cond        = slots[i].cond;
        dec_d[i].target      = slots[i].target;
        case (slots[i].kind)
          B, BL: begin
            is_end                 = 1'b1;
            dec_d[i].predict_taken = 1'b1;
          end
          RET: begin
            is_end                 = 1'b1;
            dec_d[i].predict_taken = 1'b1;
            dec_d[i].target        = ras_top;  // zero when the stack is empty
          end
          BCOND: begin
            is_end                 = predict_taken[i];
            dec_d[i].predict_taken = predict_taken[i];
          end
          default: is_end = 1'b0;
        endcase
        if (is_end) begin
          found      = 1'b1;
          end_pc     = slot_pc;
          end_target = dec_d[i].target;
          end_is_bl  = (slots[i].kind == BL);
          end_is_ret = (slots[i].kind == RET);
        end
      end
    end
    next_pc = found ? end_target : group_pc_q + XLEN'({n_valid, 2'b00});
  end

  // request and prediction control
  always_comb begin
    state_d    = state_q;
    drop_d     = drop_q;
    redir_pc_d = redir_pc_q;
    req_d      = 1'b0;
    req_pc     = group_pc_q;
    take_line  = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (redirect.valid) begin
          req_d   = 1'b1;
          req_pc  = redirect.pc;
          state_d = S_WAIT;
        end else if (start) begin
          req_d   = 1'b1;
          req_pc  = start_pc;
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (line_valid) begin
          if (redirect.valid) begin           // this line is stale, refetch at once
            req_d  = 1'b1;
            req_pc = redirect.pc;
            drop_d = 1'b0;
          end else if (drop_q) begin
            req_d  = 1'b1;
            req_pc = redir_pc_q;
            drop_d = 1'b0;
          end else begin
            take_line = 1'b1;
            state_d   = S_HOLD;
          end
        end else if (redirect.valid) begin
          drop_d     = 1'b1;
          redir_pc_d = redirect.pc;            // a later redirect wins
        end
      end
      S_HOLD: begin
        if (redirect.valid) begin             // pending prediction is dropped
          req_d   = 1'b1;
          req_pc  = redirect.pc;
          state_d = S_WAIT;
        end else if (fetch_ready) begin
          req_d   = 1'b1;
          req_pc  = pred_pc;
          state_d = S_WAIT;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state_q         <= S_IDLE;
      drop_q          <= 1'b0;
      line_req        <= 1'b0;
      decode_branches <= '0;
    end else begin
      state_q  <= state_d;
      drop_q   <= drop_d;
      line_req <= req_d;                       // one-cycle pulse
      if (take_line) begin
        decode_branches <= dec_d;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    redir_pc_q <= redir_pc_d;
    if (req_d) begin
      group_pc_q <= req_pc;
    end
    if (take_line) begin
      pred_pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== return_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module return_stack
  import bp_pkg::*;
(
  input  logic             clk_in,
  input  logic             rst_N_in,
  input  logic             push,
  input  logic             pop,
  input  logic [XLEN-1:0]  push_addr,
  output logic [XLEN-1:0]  top
);

  logic [XLEN-1:0]       mem_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0]  tos_q;          // points at the top entry
  logic [RAS_PTR_W-1:0]  wr_ptr;
  logic [RAS_CNT_W-1:0]  count_q;        // live entries

  assign wr_ptr = tos_q + 1'b1;          // wraps, so a full stack loses its oldest entry

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem_q[wr_ptr] <= push_addr;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      tos_q   <= '0;
      count_q <= '0;
    end else if (push) begin
      tos_q <= wr_ptr;
      if (count_q != RAS_CNT_W'(RAS_DEPTH)) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop && count_q != '0) begin  // pop on empty is ignored
      tos_q   <= tos_q - 1'b1;
      count_q <= count_q - 1'b1;
    end
  end

  assign top = (count_q == '0) ? '0 : mem_q[tos_q];

endmodule

`default_nettype wire

// ==== gshare_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module gshare_predictor
  import bp_pkg::*;
(
  input  logic                           clk_in,
  input  logic                           rst_N_in,
  input  logic [XLEN-1:0]                group_pc,
  input  resolve_t                       resolve,
  output logic [SUPER_SCALAR_WIDTH-1:0]  predict_taken
);

  logic [GHR_K-1:0]      ghr_q;                  // newest outcome in bit 0
  logic [1:0]            pht_q [PHT_SIZE];       // 2-bit saturating counters
  logic [PHT_IDX_W-1:0]  upd_idx;

  // per-slot lookup, reads the state before any update this cycle
  for (genvar i = 0; i < SUPER_SCALAR_WIDTH; i++) begin : g_lookup
    logic [XLEN-1:0]       slot_pc;
    logic [PHT_IDX_W-1:0]  rd_idx;

    assign slot_pc          = group_pc + XLEN'(INSTR_BYTES * i);
    assign rd_idx           = {ghr_q, slot_pc[PHT_N+1:2]};
    assign predict_taken[i] = pht_q[rd_idx][1];   // 2 or 3 means taken
  end

  // training index uses the history as it stands before the shift
  assign upd_idx = {ghr_q, resolve.pc[PHT_N+1:2]};

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr_q <= '0;
      for (int j = 0; j < PHT_SIZE; j++) begin
        pht_q[j] <= 2'b00;                    // strongly not taken
      end
    end else if (resolve.valid) begin
      if (resolve.taken) begin
        if (pht_q[upd_idx] != 2'b11) begin
          pht_q[upd_idx] <= pht_q[upd_idx] + 2'b01;
        end
      end else begin
        if (pht_q[upd_idx] != 2'b00) begin
          pht_q[upd_idx] <= pht_q[upd_idx] - 2'b01;
        end
      end
      ghr_q <= {ghr_q[GHR_K-2:0], resolve.taken}; // shift in the outcome
    end
  end

endmodule

`default_nettype wire

// ==== line_predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_predecode
  import bp_pkg::*;
(
  input  logic [XLEN-1:0]                       group_pc,
  input  logic [LINE_BITS-1:0]                  line_data,
  output slot_info_t [SUPER_SCALAR_WIDTH-1:0]   slots
);

  localparam int OFF_W = $clog2(LINE_BYTES);

  for (genvar i = 0; i < SUPER_SCALAR_WIDTH; i++) begin : g_slot
    logic [OFF_W:0]    slot_off;   // one extra bit so the line end is not wrapped
    logic [XLEN-1:0]   slot_pc;
    logic [31:0]       word;
    logic [XLEN-1:0]   imm26_off;
    logic [XLEN-1:0]   imm19_off;
    logic              in_line;

    assign slot_off = {1'b0, group_pc[OFF_W-1:0]} + (OFF_W + 1)'(INSTR_BYTES * i);
    assign slot_pc  = group_pc + XLEN'(INSTR_BYTES * i);
    assign in_line  = slot_off <= (OFF_W + 1)'(MAX_SLOT_OFF);

    // little endian bytes, byte 0 sits in bits 7:0
    assign word = line_data[{slot_off[OFF_W-1:0], 3'b000} +: 32];

    // word offsets scaled to bytes
    assign imm26_off = {{(XLEN - 28){word[25]}}, word[25:0], 2'b00};
    assign imm19_off = {{(XLEN - 21){word[23]}}, word[23:5], 2'b00};

    always_comb begin
      slots[i] = '0;
      slots[i].valid = in_line;             // past byte 60 the slot is outside the line
      slots[i].kind  = NONE;
      if (in_line) begin
        if (word[31:26] == OPC_B) begin
          slots[i].kind   = B;
          slots[i].target = slot_pc + imm26_off;
        end else if (word[31:26] == OPC_BL) begin
          slots[i].kind   = BL;
          slots[i].target = slot_pc + imm26_off;
        end else if (word[31:21] == RET_PATTERN) begin
          slots[i].kind   = RET;        // target comes from the return stack
        end else if (word[31:24] == BCOND_PREFIX) begin
          slots[i].kind   = BCOND;
          slots[i].cond   = word[3:0];
          slots[i].target = slot_pc + imm19_off;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bp_pkg.sv ====
`default_nettype none

package bp_pkg;

  // core widths
  localparam int XLEN        = 64;
  localparam int INSTR_BYTES = 4;                       // fixed 32-bit instructions

  // cache line geometry
  localparam int LINE_BYTES   = 64;
  localparam int LINE_BITS    = LINE_BYTES * 8;
  localparam int MAX_SLOT_OFF = LINE_BYTES - INSTR_BYTES; // last slot offset in a line

  // fetch group
  localparam int SUPER_SCALAR_WIDTH = 2;
  localparam int SLOT_CNT_W         = $clog2(SUPER_SCALAR_WIDTH + 1);

  // gshare sizing
  localparam int GHR_K     = 4;
  localparam int PHT_N     = 4;
  localparam int PHT_IDX_W = GHR_K + PHT_N;
  localparam int PHT_SIZE  = 1 << PHT_IDX_W;            // 256 counters

  // return stack sizing
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = $clog2(RAS_DEPTH);
  localparam int RAS_CNT_W = $clog2(RAS_DEPTH + 1);

  // instruction encodings
  localparam logic [5:0]  OPC_B        = 6'b000101;     // bits 31:26, imm26 below
  localparam logic [5:0]  OPC_BL       = 6'b100101;     // bits 31:26, imm26 below
  localparam logic [10:0] RET_PATTERN  = 11'b11010110010; // bits 31:21
  localparam logic [7:0]  BCOND_PREFIX = 8'b01010100;   // bits 31:24, imm19 in 23:5

  typedef enum logic [2:0] {
    NONE,
    B,
    BL,
    RET,
    BCOND
  } instr_kind_t;

  // predecode view of one slot
  typedef struct packed {
    logic             valid;
    instr_kind_t      kind;
    logic [3:0]       cond;
    logic [XLEN-1:0]  target;   // zero for RET, filled from the stack later
  } slot_info_t;

  // one slot as handed to decode
  typedef struct packed {
    logic             valid;
    instr_kind_t      kind;
    logic [3:0]       cond;
    logic             predict_taken;
    logic [XLEN-1:0]  target;
  } branch_info_t;

  typedef branch_info_t [SUPER_SCALAR_WIDTH-1:0] branch_group_t;

  // branch outcome from execute
  typedef struct packed {
    logic             valid;
    logic             taken;
    logic [XLEN-1:0]  pc;
  } resolve_t;

  // fetch restart from execute
  typedef struct packed {
    logic             valid;
    logic [XLEN-1:0]  pc;
  } redirect_t;

endpackage

`default_nettype wire
